/* hdl/alu.sv */
// Combinational ALU for the core subset
// Add and sub wrap without overflow detection; slt is signed

`timescale 1ns/100ps
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_op_e   alu_op,
    output word_t     result,
    output logic      zero
);

    always_comb
    begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            // 1 when a < b as two's complement
            alu_slt:
            begin
                result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            end
            default: result = '0;
        endcase
    end

    // Used by beq after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/data_memory.sv */
// Word-organized data memory, no byte lanes
// Loads mem_init while rst is high; contents are lost on every reset
// addr is a byte address; the two low bits are ignored

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module data_memory
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire [`WORD_W*`DMEM_N-1:0]    mem_init,
    output logic [`WORD_W*`DMEM_N-1:0]   mem_image,
    input  wire [`DMEM_L+1:0]            addr,
    input  wire [`WORD_W-1:0]            data_in,
    input  wire                          mem_write,
    output logic [`WORD_W-1:0]           data_out
);

    logic [`WORD_W-1:0] mem [0:`DMEM_N-1];

    // Word index from byte address
    logic [`DMEM_L-1:0] word_idx;
    assign word_idx = addr[`DMEM_L+1:2];

    // Load on reset, single-word write otherwise
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DMEM_N; i++)
            begin
                mem[i] <= mem_init[i*`WORD_W +: `WORD_W];
            end
        end
        else if (mem_write)
        begin
            mem[word_idx] <= data_in;
        end
    end

    // Combinational read, valid in the address cycle
    assign data_out = mem[word_idx];

    // Whole contents, word 0 in the low bits
    for (genvar g = 0; g < `DMEM_N; g++)
    begin : g_image
        assign mem_image[g*`WORD_W +: `WORD_W] = mem[g];
    end

endmodule

`default_nettype wire

/* hdl/instr_memory.sv */
// Read-only program store, no write port
// Program image is copied from mem_init while rst is high
// addr is a byte address; the two low bits are ignored

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module instr_memory
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire [`WORD_W*`IMEM_N-1:0]    mem_init,
    input  wire [`IMEM_L+1:0]            addr,
    output logic [`WORD_W-1:0]           instr
);

    logic [`WORD_W-1:0] mem [0:`IMEM_N-1];

    // Contents only change under reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `IMEM_N; i++)
            begin
                mem[i] <= mem_init[i*`WORD_W +: `WORD_W];
            end
        end
    end

    // Fetch is zero-cycle
    assign instr = mem[addr[`IMEM_L+1:2]];

endmodule

`default_nettype wire

/* hdl/main_control.sv */
// Single-cycle instruction decoder
// All outputs are forced low while rst is high, so no writes during load
// Unknown opcode or function code decodes as a no-op

`timescale 1ns/100ps
`default_nettype none

module main_control
    import mips_pkg::*;
(
    input  wire       rst,
    input  opcode_e   opcode,
    input  funct_e    funct,
    output logic      reg_dst,
    output logic      alu_src,
    output logic      mem_to_reg,
    output logic      reg_write,
    output logic      mem_read,
    output logic      mem_write,
    output logic      branch,
    output alu_op_e   alu_op
);

    always_comb
    begin
        // Defaults give a no-op
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        alu_op     = alu_add;

        if (!rst)
        begin
            case (opcode)
                op_rtype:
                begin
                    // Destination in rd, operation from funct
                    reg_dst   = 1'b1;
                    reg_write = 1'b1;
                    case (funct)
                        fn_add:  alu_op = alu_add;
                        fn_sub:  alu_op = alu_sub;
                        fn_and:  alu_op = alu_and;
                        fn_or:   alu_op = alu_or;
                        fn_slt:  alu_op = alu_slt;
                        default: reg_write = 1'b0;
                    endcase
                end
                op_lw:
                begin
                    alu_src    = 1'b1;
                    mem_to_reg = 1'b1;
                    mem_read   = 1'b1;
                    reg_write  = 1'b1;
                end
                op_sw:
                begin
                    alu_src   = 1'b1;
                    mem_write = 1'b1;
                end
                op_addi:
                begin
                    alu_src   = 1'b1;
                    reg_write = 1'b1;
                end
                // Compare by subtract, zero flag decides
                op_beq:
                begin
                    branch = 1'b1;
                    alu_op = alu_sub;
                end
                default:
                begin
                    branch = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_core_top.sv */
// Single-cycle MIPS subset core, one instruction per clock
// Both memories load their init vectors while rst is high
// Only PC bits up to IMEM_L+1 reach the instruction memory

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_core_top
    import mips_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire [`WORD_W*`IMEM_N-1:0]    imem_init,
    input  wire [`WORD_W*`DMEM_N-1:0]    dmem_init,
    output logic [`WORD_W*`DMEM_N-1:0]   dmem_image,
    output word_t                        pc
);

    word_t              instr;
    opcode_e            opcode;
    funct_e             funct;
    logic [`REG_L-1:0]  rs_idx;
    logic [`REG_L-1:0]  rt_idx;
    logic [`REG_L-1:0]  rd_idx;
    logic [`REG_L-1:0]  wr_idx;
    word_t              imm_ext;

    logic               reg_dst;
    logic               alu_src;
    logic               mem_to_reg;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               branch;
    alu_op_e            alu_op;

    word_t              rs_data;
    word_t              rt_data;
    word_t              alu_b;
    word_t              alu_result;
    logic               zero;
    word_t              dmem_rdata;
    word_t              load_data;
    word_t              wb_data;

    // ===========================================================================
    // Fetch and field split
    // ===========================================================================
    pc_unit u_pc_unit
    (
        .clk    (clk),
        .rst    (rst),
        .branch (branch),
        .zero   (zero),
        .imm    (imm_ext),
        .pc     (pc)
    );

    instr_memory u_instr_memory
    (
        .clk      (clk),
        .rst      (rst),
        .mem_init (imem_init),
        .addr     (pc[`IMEM_L+1:0]),
        .instr    (instr)
    );

    assign opcode  = opcode_e'(instr[31:26]);
    assign funct   = funct_e'(instr[5:0]);
    assign rs_idx  = instr[25:21];
    assign rt_idx  = instr[20:16];
    assign rd_idx  = instr[15:11];
    // Sign extend the 16-bit immediate
    assign imm_ext = {{(`WORD_W-16){instr[15]}}, instr[15:0]};

    // ===========================================================================
    // Decode, register read, execute
    // ===========================================================================
    main_control u_main_control
    (
        .rst        (rst),
        .opcode     (opcode),
        .funct      (funct),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .alu_op     (alu_op)
    );

    // rd for R-type, rt for addi and lw
    assign wr_idx = reg_dst ? rd_idx : rt_idx;

    register_file u_register_file
    (
        .clk       (clk),
        .rst       (rst),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rd_idx    (wr_idx),
        .rd_data   (wb_data),
        .reg_write (reg_write),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    assign alu_b = alu_src ? imm_ext : rt_data;

    alu u_alu
    (
        .a      (rs_data),
        .b      (alu_b),
        .alu_op (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // ===========================================================================
    // Memory access and write-back
    // ===========================================================================
    data_memory u_data_memory
    (
        .clk       (clk),
        .rst       (rst),
        .mem_init  (dmem_init),
        .mem_image (dmem_image),
        .addr      (alu_result[`DMEM_L+1:0]),
        .data_in   (rt_data),
        .mem_write (mem_write),
        .data_out  (dmem_rdata)
    );

    // Read data only passed on a load
    assign load_data = mem_read ? dmem_rdata : '0;
    assign wb_data   = mem_to_reg ? load_data : alu_result;

endmodule

`default_nettype wire

/* hdl/mips_pkg.sv */
// Shared types for the single-cycle core
// Encodings follow the classic MIPS subset; only listed codes are legal
// Anything else decodes as a no-op in main_control

`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

    // Datapath word
    typedef logic [`WORD_W-1:0] word_t;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0]
    {
        op_rtype = 6'd0,
        op_beq   = 6'd4,
        op_addi  = 6'd8,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0]
    {
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_slt = 6'd42
    } funct_e;

    // Internal ALU selector, not an ISA encoding
    typedef enum logic [2:0]
    {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

endpackage

`default_nettype wire

/* hdl/pc_unit.sv */
// Program counter, byte address, always word aligned
// Branch target is PC+4 plus the word offset in imm

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module pc_unit
    import mips_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     branch,
    input  wire     zero,
    input  word_t   imm,
    output word_t   pc
);

    word_t pc_plus4;
    word_t branch_target;
    logic  take_branch;

    assign pc_plus4      = pc + word_t'(4);
    // Offset counts words, shift into bytes
    assign branch_target = pc_plus4 + {imm[`WORD_W-3:0], 2'b00};
    assign take_branch   = branch & zero;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= '0;
        else
            pc <= take_branch ? branch_target : pc_plus4;
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
// 32 x WORD_W register file, two async read ports, one sync write port
// No write-to-read bypass; a same-cycle write is seen after the edge

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module register_file
    import mips_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire [`REG_L-1:0]      rs_idx,
    input  wire [`REG_L-1:0]      rt_idx,
    input  wire [`REG_L-1:0]      rd_idx,
    input  word_t                 rd_data,
    input  wire                   reg_write,
    output word_t                 rs_data,
    output word_t                 rt_data
);

    word_t regs [0:`REG_N-1];

    // Register 0 never gets written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_N; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (reg_write && (rd_idx != '0))
        begin
            regs[rd_idx] <= rd_data;
        end
    end

    // Reads, with $zero forced
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

/* include/mips_defines.svh */
// Sizing for the single-cycle core
// Memories are word organized; byte offsets in addresses are dropped
// Depths must be powers of two, given as log2 values

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ===========================================================================
// Word and index widths
// ===========================================================================
`define WORD_W 32
`define REG_L  5
`define REG_N  (1 << `REG_L)

// ===========================================================================
// Memory depths in words
// ===========================================================================
`define DMEM_L 6
`define DMEM_N (1 << `DMEM_L)
`define IMEM_L 5
`define IMEM_N (1 << `IMEM_L)

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module mips_tb -f sources.f -Mdir obj_dir -o mips_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/mips_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+include
hdl/mips_pkg.sv
hdl/data_memory.sv
hdl/instr_memory.sv
hdl/register_file.sv
hdl/alu.sv
hdl/main_control.sv
hdl/pc_unit.sv
hdl/mips_core_top.sv
tests/tb_clock_gen.sv
tests/mips_checker.sv
tests/mips_tb.sv

/* tests/mips_checker.sv */
// Concurrent checks bound into mips_core_top, sampled on the rising clock
// pc alignment is only checked outside reset

`timescale 1ns/100ps
`default_nettype none

module mips_checker
    import mips_pkg::*;
(
    input wire   clk,
    input wire   rst,
    input word_t pc,
    input wire   mem_write
);

    // Fetch addresses stay on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

    // First cycle out of reset fetches from address zero
    pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
        else $error("pc nonzero in the first cycle after reset: %h", pc);

    // Decoder gating keeps the data memory quiet while images load
    no_write_in_reset: assert property (@(posedge clk) rst |-> !mem_write)
        else $error("mem_write active during reset");

endmodule

bind mips_core_top mips_checker u_mips_checker
(
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .mem_write (mem_write)
);

`default_nettype wire

/* tests/mips_tb.sv */
// Directed tests for the single-cycle core
// Each test builds its own program and data image, resets, runs to the idle loop
// Results are observed only through dmem_image and pc

`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_tb
    import mips_pkg::*;
();

    localparam int TEST_COUNT      = 5;
    localparam int CYCLE_BUDGET    = 200;
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_LIMIT      = 150;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (CYCLE_BUDGET + RESET_CYCLES);

    wire                          clk;
    logic                         rst;
    logic [`WORD_W*`IMEM_N-1:0]   imem_init;
    logic [`WORD_W*`DMEM_N-1:0]   dmem_init;
    wire  [`WORD_W*`DMEM_N-1:0]   dmem_image;
    word_t                        pc;

    // Test-side images, packed into the init vectors before reset
    word_t prog      [0:`IMEM_N-1];
    word_t data_init [0:`DMEM_N-1];
    word_t dmem_exp  [0:`DMEM_N-1];
    word_t rng_state;
    int    mismatch_count;
    int    failure_count;

    tb_clock_gen u_tb_clock_gen
    (
        .clk (clk)
    );

    mips_core_top u_mips_core_top
    (
        .clk        (clk),
        .rst        (rst),
        .imem_init  (imem_init),
        .dmem_init  (dmem_init),
        .dmem_image (dmem_image),
        .pc         (pc)
    );

    // ========================================================================
    // Instruction encoding and data patterns
    // ========================================================================
    function automatic word_t r_type(input funct_e fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // beq $0,$0,-1 branches onto itself
    function automatic word_t idle_loop();
        return i_type(op_beq, 5'd0, 5'd0, 16'hFFFF);
    endfunction

    // Odd multiplier keeps every word index distinct
    function automatic word_t fill_pattern(input int idx);
        return 32'hA500_0000 ^ (word_t'(idx) * 32'h0001_0203);
    endfunction

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ========================================================================
    // Image setup, reset and run control
    // ========================================================================
    task automatic new_program();
        for (int i = 0; i < `IMEM_N; i++)
        begin
            prog[i] = idle_loop();
        end
    endtask

    task automatic pattern_data();
        for (int i = 0; i < `DMEM_N; i++)
        begin
            data_init[i] = fill_pattern(i);
            dmem_exp[i]  = data_init[i];
        end
    endtask

    task automatic random_data();
        for (int i = 0; i < `DMEM_N; i++)
        begin
            rng_state    = xorshift32(rng_state);
            data_init[i] = rng_state;
            dmem_exp[i]  = rng_state;
        end
    endtask

    // Pass when pc holds for two cycles in a row
    task automatic wait_idle(input int test_id);
        word_t last;
        int    stable;
        int    cycles;
        last   = pc;
        stable = 0;
        cycles = 0;
        while (stable < 2 && cycles < IDLE_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            if (pc == last)
            begin
                stable++;
            end
            else
            begin
                stable = 0;
            end
            last = pc;
        end
        if (stable < 2)
        begin
            $display("Test %0d: program never reached its idle loop within %0d cycles",
                     test_id, IDLE_LIMIT);
            failure_count++;
        end
    endtask

    task automatic run_program(input int test_id);
        @(negedge clk);
        for (int i = 0; i < `IMEM_N; i++)
        begin
            imem_init[i*`WORD_W +: `WORD_W] = prog[i];
        end
        for (int i = 0; i < `DMEM_N; i++)
        begin
            dmem_init[i*`WORD_W +: `WORD_W] = data_init[i];
        end
        // Images load while reset is high
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        wait_idle(test_id);
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_pc(input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH pc expected %h actual %h", expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_image();
        for (int i = 0; i < `DMEM_N; i++)
        begin
            check_word($sformatf("dmem_image[%0d]", i), dmem_exp[i],
                       dmem_image[i*`WORD_W +: `WORD_W]);
        end
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    // Only the idle loop, memory must come back as loaded
    task automatic test_reset_load();
        new_program();
        pattern_data();
        run_program(1);
        check_image();
        check_pc(32'd0, pc);
    endtask

    task automatic test_arithmetic();
        new_program();
        prog[0] = i_type(op_addi, 5'd1, 5'd0, 16'd25);
        prog[1] = i_type(op_addi, 5'd2, 5'd0, 16'hFFF9);
        prog[2] = r_type(fn_add, 5'd3, 5'd1, 5'd2);
        prog[3] = r_type(fn_sub, 5'd4, 5'd2, 5'd1);
        prog[4] = r_type(fn_and, 5'd5, 5'd1, 5'd2);
        prog[5] = r_type(fn_or,  5'd6, 5'd1, 5'd2);
        prog[6] = r_type(fn_slt, 5'd7, 5'd2, 5'd1);
        prog[7] = r_type(fn_slt, 5'd8, 5'd1, 5'd2);
        // r3..r8 to words 0..5
        for (int k = 0; k < 6; k++)
        begin
            prog[8 + k] = i_type(op_sw, 5'(3 + k), 5'd0, 16'(4 * k));
        end
        pattern_data();
        // 25 + -7 = 18, -7 - 25 = -32
        dmem_exp[0] = 32'd18;
        dmem_exp[1] = 32'hFFFF_FFE0;
        // 0x19 against 0xFFFFFFF9 bit by bit
        dmem_exp[2] = 32'h0000_0019;
        dmem_exp[3] = 32'hFFFF_FFF9;
        // Signed: -7 < 25 but not the reverse
        dmem_exp[4] = 32'd1;
        dmem_exp[5] = 32'd0;
        run_program(2);
        check_image();
        check_pc(32'd56, pc);
    endtask

    task automatic test_load_store();
        new_program();
        prog[0] = i_type(op_addi, 5'd3, 5'd0, 16'd32);
        prog[1] = i_type(op_lw,   5'd1, 5'd3, 16'd8);
        prog[2] = i_type(op_addi, 5'd2, 5'd1, 16'h0123);
        prog[3] = i_type(op_sw,   5'd2, 5'd3, 16'd16);
        // Negative offset, byte 28
        prog[4] = i_type(op_sw,   5'd2, 5'd3, 16'hFFFC);
        pattern_data();
        data_init[10] = 32'h1234_5678;
        dmem_exp[10]  = 32'h1234_5678;
        dmem_exp[12]  = 32'h1234_5678 + 32'h0000_0123;
        dmem_exp[7]   = 32'h1234_5678 + 32'h0000_0123;
        run_program(3);
        check_image();
        check_pc(32'd20, pc);
    endtask

    task automatic test_branch();
        new_program();
        prog[0] = i_type(op_addi, 5'd1, 5'd0, 16'd9);
        prog[1] = i_type(op_addi, 5'd2, 5'd0, 16'd9);
        prog[2] = i_type(op_addi, 5'd3, 5'd0, 16'd4);
        prog[3] = i_type(op_addi, 5'd4, 5'd0, 16'd77);
        // Equal, skips the next store
        prog[4] = i_type(op_beq,  5'd2, 5'd1, 16'd1);
        prog[5] = i_type(op_sw,   5'd4, 5'd0, 16'd0);
        // Unequal, falls through
        prog[6] = i_type(op_beq,  5'd3, 5'd1, 16'd1);
        prog[7] = i_type(op_sw,   5'd4, 5'd0, 16'd4);
        pattern_data();
        dmem_exp[1] = 32'd77;
        run_program(4);
        check_image();
        check_pc(32'd32, pc);
    endtask

    task automatic test_zero_register();
        new_program();
        prog[0] = i_type(op_addi, 5'd0, 5'd0, 16'd100);
        prog[1] = i_type(op_addi, 5'd1, 5'd0, 16'd3);
        prog[2] = r_type(fn_add, 5'd0, 5'd1, 5'd1);
        prog[3] = i_type(op_sw,   5'd0, 5'd0, 16'd20);
        prog[4] = r_type(fn_add, 5'd2, 5'd0, 5'd1);
        prog[5] = i_type(op_sw,   5'd2, 5'd0, 16'd24);
        prog[6] = i_type(op_lw,   5'd0, 5'd0, 16'd28);
        prog[7] = i_type(op_sw,   5'd0, 5'd0, 16'd32);
        random_data();
        dmem_exp[5] = 32'd0;
        dmem_exp[6] = 32'd3;
        dmem_exp[8] = 32'd0;
        run_program(5);
        check_image();
        check_pc(32'd32, pc);
    endtask

    // ========================================================================
    // Sequence and watchdog
    // ========================================================================
    initial
    begin
        rst            = 1'b1;
        imem_init      = '0;
        dmem_init      = '0;
        mismatch_count = 0;
        failure_count  = 0;
        rng_state      = 32'd54;
        test_reset_load();
        test_arithmetic();
        test_load_store();
        test_branch();
        test_zero_register();
        $display("Error count: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Free-running testbench clock, starts low
// Period is twice HALF_PERIOD_NS, 4 ns by default

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
    parameter int HALF_PERIOD_NS = 2
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
